// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_shader
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dirpint.sv
`timescale 1ns/1ns
`include "shader_defines.svh"

module dirpint (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                we,
  input  shader_pkg::rayid_t                  waddr,
  input  shader_pkg::ray_vec_t                wdata,
  input  shader_pkg::scache_to_shader_t       scache_data,
  input  logic                                scache_valid,
  output logic                                scache_stall,
  output shader_pkg::dirpint_to_calc_direct_t calc_direct_data,
  output logic                                calc_direct_valid,
  input  logic                                calc_direct_stall,
  output shader_pkg::dirpint_to_sendreflect_t reflect_data,
  output logic                                reflect_valid,
  input  logic                                reflect_stall
);

  import shader_pkg::*;

  typedef struct packed {
    rayid_t    rayid;
    vector24_t normal;
    float24_t  f_color;
    float16_t  spec;
    vector_t   p_int;
    vector_t   dir;
    logic      is_miss;
    logic      is_shadow;
    logic      is_last;
  } merged_t;

  scache_to_shader_t stage_hit;
  logic              stage_valid;
  logic              hit_accept;
  ray_vec_t          ray_vec;
  merged_t           merge_in;
  merged_t           merge_head;
  logic              merge_we;
  logic              merge_re;
  logic              merge_full;
  logic              merge_empty;
  logic              is_candidate;
  logic              release_head;

  function automatic vector_t widen_vec(input vector24_t v);
    vector_t w;
    w.x = {v.x, 8'h00};
    w.y = {v.y, 8'h00};
    w.z = {v.z, 8'h00};
    return w;
  endfunction

  // ***************************************************************************
  // Hit stage, waits one cycle for the ray memory
  // ***************************************************************************

  assign scache_stall = stage_valid & merge_full;  // Occupied and cannot drain
  assign hit_accept   = scache_valid & ~scache_stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else if (!scache_stall) begin
      stage_valid <= scache_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_accept) begin
      stage_hit <= scache_data;
    end
  end

  ray_bram u_ray_bram (
    .clk,
    .we,
    .waddr,
    .wdata,
    .re    (hit_accept),  // Read data holds along with the stage
    .raddr (scache_data.rayid),
    .rdata (ray_vec)
  );

  // ***************************************************************************
  // Merge queue and output split
  // ***************************************************************************

  always_comb begin
    merge_in.rayid     = stage_hit.rayid;
    merge_in.normal    = stage_hit.normal;
    merge_in.f_color   = stage_hit.f_color;
    merge_in.spec      = stage_hit.spec;
    merge_in.p_int     = ray_vec.origin;
    merge_in.dir       = ray_vec.dir;
    merge_in.is_miss   = stage_hit.is_miss;
    merge_in.is_shadow = stage_hit.is_shadow;
    merge_in.is_last   = stage_hit.is_last;
  end

  assign merge_we = stage_valid & ~merge_full;

  fifo #(
    .payload_t (merged_t),
    .DEPTH     (`DIRPINT_FIFO_DEPTH)
  ) u_merge_fifo (
    .clk,
    .reset,
    .we       (merge_we),
    .data_in  (merge_in),
    .re       (merge_re),
    .data_out (merge_head),
    .full     (merge_full),
    .empty    (merge_empty)
  );

  // A bounce is spawned for hits that are neither the last one nor a miss
  assign is_candidate = ~merge_head.is_last & ~merge_head.is_miss;
  assign release_head = ~merge_empty & ~calc_direct_stall & (~is_candidate | ~reflect_stall);

  assign merge_re          = release_head;
  assign calc_direct_valid = release_head;
  assign reflect_valid     = release_head & is_candidate;

  always_comb begin
    calc_direct_data.rayid     = merge_head.rayid;
    calc_direct_data.K         = {merge_head.f_color, 8'h00};
    calc_direct_data.N         = widen_vec(merge_head.normal);
    calc_direct_data.p_int     = merge_head.p_int;
    calc_direct_data.spec      = merge_head.spec;
    calc_direct_data.is_miss   = merge_head.is_miss;
    calc_direct_data.is_shadow = merge_head.is_shadow;
    calc_direct_data.is_last   = merge_head.is_last;

    reflect_data.rayid  = merge_head.rayid;
    reflect_data.normal = widen_vec(merge_head.normal);
    reflect_data.p_int  = merge_head.p_int;
    reflect_data.dir    = merge_head.dir;
  end

endmodule

// File: fifo.sv
`timescale 1ns/1ns

module fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     we,
  input  payload_t data_in,
  input  logic     re,
  output payload_t data_out,
  output logic     full,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_write;
  logic             do_read;

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign do_write = we & ~full;   // Writes into a full queue are dropped
  assign do_read  = re & ~empty;
  assign data_out = mem[rd_ptr];  // Head shows while not empty

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: ray_bram.sv
`timescale 1ns/1ns

module ray_bram (
  input  logic                 clk,
  input  logic                 we,
  input  shader_pkg::rayid_t   waddr,
  input  shader_pkg::ray_vec_t wdata,
  input  logic                 re,
  input  shader_pkg::rayid_t   raddr,
  output shader_pkg::ray_vec_t rdata
);

  import shader_pkg::*;

  localparam int ENTRIES = 2 ** $bits(rayid_t);

  ray_vec_t mem [ENTRIES];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Same-address read and write in one cycle returns the old vectors
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// File: shade_direct.sv
`timescale 1ns/1ns
`include "shader_defines.svh"

module shade_direct (
  input  logic                                clk,
  input  logic                                reset,
  input  shader_pkg::dirpint_to_calc_direct_t in_data,
  input  logic                                in_valid,
  output logic                                in_stall,
  output shader_pkg::pixel_t                  pixel_data,
  output logic                                pixel_valid,
  input  logic                                pixel_stall
);

  import shader_pkg::*;

  pixel_t pix_next;
  pixel_t stage_pix;
  logic   stage_valid;
  logic   in_accept;
  logic   lit;
  logic   pix_we;
  logic   pix_re;
  logic   pix_full;
  logic   pix_empty;

  assign lit = ~in_data.is_miss & ~in_data.is_shadow;

  always_comb begin
    pix_next.rayid   = in_data.rayid;
    pix_next.is_last = in_data.is_last;
    pix_next.spec    = lit ? in_data.spec : '0;
    if (in_data.is_miss) begin
      pix_next.color = `BG_COLOR;
    end else if (in_data.is_shadow) begin
      pix_next.color = '0;        // Light is blocked
    end else begin
      pix_next.color = in_data.K;
    end
  end

  // ***************************************************************************
  // Colour stage and pixel queue
  // ***************************************************************************

  assign in_stall  = stage_valid & pix_full;
  assign in_accept = in_valid & ~in_stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else if (!in_stall) begin
      stage_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_accept) begin
      stage_pix <= pix_next;
    end
  end

  assign pix_we      = stage_valid & ~pix_full;
  assign pix_re      = ~pix_empty & ~pixel_stall;
  assign pixel_valid = ~pix_empty;  // Head stays put while stalled

  fifo #(
    .payload_t (pixel_t),
    .DEPTH     (`PIXEL_FIFO_DEPTH)
  ) u_pixel_fifo (
    .clk,
    .reset,
    .we       (pix_we),
    .data_in  (stage_pix),
    .re       (pix_re),
    .data_out (pixel_data),
    .full     (pix_full),
    .empty    (pix_empty)
  );

endmodule

// File: shader_defines.svh
`ifndef SHADER_DEFINES_SVH
`define SHADER_DEFINES_SVH

// ***************************************************************************
// Widths and depths
// ***************************************************************************

`define RAYID_W            9
`define DIRPINT_FIFO_DEPTH 3
`define PIXEL_FIFO_DEPTH   2

// Float pattern of the background seen by missed rays (0.2)
`define BG_COLOR 32'h3e4c_cccd

`endif

// File: shader_pkg.sv
`include "shader_defines.svh"

package shader_pkg;

  typedef logic [`RAYID_W-1:0] rayid_t;

  typedef logic [15:0] float16_t;
  typedef logic [23:0] float24_t;
  typedef logic [31:0] float32_t;

  typedef struct packed {
    float24_t x;
    float24_t y;
    float24_t z;
  } vector24_t;

  typedef struct packed {
    float32_t x;
    float32_t y;
    float32_t z;
  } vector_t;

  typedef struct packed {
    vector_t origin;  // Intersection point
    vector_t dir;
  } ray_vec_t;

  // ***************************************************************************
  // Records passed between the shader stages
  // ***************************************************************************

  typedef struct packed {
    rayid_t    rayid;
    vector24_t normal;
    float24_t  f_color;
    float16_t  spec;
    logic      is_miss;
    logic      is_shadow;
    logic      is_last;
  } scache_to_shader_t;

  typedef struct packed {
    rayid_t   rayid;
    float32_t K;          // Surface colour widened to 32 bits
    vector_t  N;
    vector_t  p_int;
    float16_t spec;
    logic     is_miss;
    logic     is_shadow;
    logic     is_last;
  } dirpint_to_calc_direct_t;

  typedef struct packed {
    rayid_t  rayid;
    vector_t normal;
    vector_t p_int;
    vector_t dir;
  } dirpint_to_sendreflect_t;

  typedef struct packed {
    rayid_t   rayid;
    float32_t color;
    float16_t spec;
    logic     is_last;
  } pixel_t;

endpackage

// File: shader_top.sv
`timescale 1ns/1ns

module shader_top (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                we,
  input  shader_pkg::rayid_t                  waddr,
  input  shader_pkg::ray_vec_t                wdata,
  input  shader_pkg::scache_to_shader_t       scache_data,
  input  logic                                scache_valid,
  output logic                                scache_stall,
  output shader_pkg::dirpint_to_sendreflect_t reflect_data,
  output logic                                reflect_valid,
  input  logic                                reflect_stall,
  output shader_pkg::pixel_t                  pixel_data,
  output logic                                pixel_valid,
  input  logic                                pixel_stall
);

  import shader_pkg::*;

  // Link from decode to direct shading
  dirpint_to_calc_direct_t calc_direct_data;
  logic                    calc_direct_valid;
  logic                    calc_direct_stall;

  dirpint u_dirpint (
    .clk,
    .reset,
    .we,
    .waddr,
    .wdata,
    .scache_data,
    .scache_valid,
    .scache_stall,
    .calc_direct_data,
    .calc_direct_valid,
    .calc_direct_stall,
    .reflect_data,
    .reflect_valid,
    .reflect_stall
  );

  shade_direct u_shade_direct (
    .clk,
    .reset,
    .in_data     (calc_direct_data),
    .in_valid    (calc_direct_valid),
    .in_stall    (calc_direct_stall),
    .pixel_data,
    .pixel_valid,
    .pixel_stall
  );

endmodule

// File: src.f
+incdir+.
shader_pkg.sv
ray_bram.sv
fifo.sv
dirpint.sv
shade_direct.sv
shader_top.sv
tb_shader_assert.sv
tb_shader.sv

// File: tb_shader.sv
`timescale 1ns/1ns
`include "shader_defines.svh"

module tb_shader;

  import shader_pkg::*;

  localparam int NUM_RAYS    = 64;
  localparam int NUM_HITS    = 300;
  localparam int CYCLE_LIMIT = 40 * NUM_HITS + 200;

  logic                    clk;
  logic                    reset;
  logic                    we;
  rayid_t                  waddr;
  ray_vec_t                wdata;
  scache_to_shader_t       scache_data;
  logic                    scache_valid;
  logic                    scache_stall;
  dirpint_to_sendreflect_t reflect_data;
  logic                    reflect_valid;
  logic                    reflect_stall;
  pixel_t                  pixel_data;
  logic                    pixel_valid;
  logic                    pixel_stall;

  integer                  seed = 31048;
  int                      cycle_count = 0;
  rayid_t                  ids [NUM_RAYS];
  ray_vec_t                model_mem [2 ** `RAYID_W];
  pixel_t                  exp_pix [$];
  dirpint_to_sendreflect_t exp_ref [$];

  shader_top DUT (
    .clk,
    .reset,
    .we,
    .waddr,
    .wdata,
    .scache_data,
    .scache_valid,
    .scache_stall,
    .reflect_data,
    .reflect_valid,
    .reflect_stall,
    .pixel_data,
    .pixel_valid,
    .pixel_stall
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ***************************************************************************
  // Random helpers and the reference model
  // ***************************************************************************

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic ray_vec_t rand_ray();
    ray_vec_t v;
    v = {$random(seed), $random(seed), $random(seed),
         $random(seed), $random(seed), $random(seed)};
    return v;
  endfunction

  function automatic scache_to_shader_t random_hit();
    scache_to_shader_t h;
    h.rayid     = ids[rand_below(NUM_RAYS)];
    h.normal.x  = float24_t'($random(seed));
    h.normal.y  = float24_t'($random(seed));
    h.normal.z  = float24_t'($random(seed));
    h.f_color   = float24_t'($random(seed));
    h.spec      = float16_t'($random(seed));
    h.is_miss   = (rand_below(4) == 0);
    h.is_shadow = (rand_below(3) == 0);
    h.is_last   = (rand_below(3) == 0);
    return h;
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic push_expected(input scache_to_shader_t h);
    pixel_t                  p;
    dirpint_to_sendreflect_t r;
    ray_vec_t                v;
    v         = model_mem[h.rayid];  // Vectors as they were before this edge
    p.rayid   = h.rayid;
    p.is_last = h.is_last;
    if (h.is_miss) begin
      p.color = `BG_COLOR;
      p.spec  = '0;
    end else if (h.is_shadow) begin
      p.color = '0;
      p.spec  = '0;
    end else begin
      p.color = {h.f_color, 8'h00};
      p.spec  = h.spec;
    end
    exp_pix.push_back(p);
    if (!h.is_last && !h.is_miss) begin
      r.rayid    = h.rayid;
      r.normal.x = {h.normal.x, 8'h00};
      r.normal.y = {h.normal.y, 8'h00};
      r.normal.z = {h.normal.z, 8'h00};
      r.p_int    = v.origin;
      r.dir      = v.dir;
      exp_ref.push_back(r);
    end
  endtask

  task automatic compare_pixel(input pixel_t actual);
    pixel_t expected;
    if (exp_pix.size() == 0) begin
      $display("A pixel for ray %0d came out with no hit left to match it", actual.rayid);
      abort_run();
    end
    expected = exp_pix.pop_front();
    if (actual !== expected) begin
      $display("FAILED at %0t ns: pixel mismatch, expected %h got %h",
               $time, expected, actual);
      abort_run();
    end
  endtask

  task automatic compare_reflect(input dirpint_to_sendreflect_t actual);
    dirpint_to_sendreflect_t expected;
    if (exp_ref.size() == 0) begin
      $display("A reflection for ray %0d came out with no candidate hit to match it",
               actual.rayid);
      abort_run();
    end
    expected = exp_ref.pop_front();
    if (actual !== expected) begin
      $display("FAILED at %0t ns: reflection mismatch, expected %h got %h",
               $time, expected, actual);
      abort_run();
    end
  endtask

  // Transfers are sampled at the rising edge, where every signal has settled
  always @(posedge clk) begin
    if (!reset) begin
      if (scache_valid && !scache_stall) begin
        push_expected(scache_data);
      end
      if (we) begin
        model_mem[waddr] = wdata;  // Applied after the read of the same edge
      end
      if (pixel_valid && !pixel_stall) begin
        compare_pixel(pixel_data);
      end
      if (reflect_valid && !reflect_stall) begin
        compare_reflect(reflect_data);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timed out after %0d cycles with %0d pixels and %0d reflections pending",
               cycle_count, exp_pix.size(), exp_ref.size());
      abort_run();
    end
  end

  // Back-pressure on both outputs, roughly 30 % of the cycles each
  initial begin
    logic next_reflect_stall;
    logic next_pixel_stall;
    reflect_stall = 1'b0;
    pixel_stall   = 1'b0;
    forever begin
      @(posedge clk);  // Next stall values are drawn here
      next_reflect_stall = !reset && (rand_below(10) < 3);
      next_pixel_stall   = !reset && (rand_below(10) < 3);
      @(negedge clk);
      reflect_stall = next_reflect_stall;
      pixel_stall   = next_pixel_stall;
    end
  end

  // ***************************************************************************
  // Stimulus
  // ***************************************************************************

  task automatic write_ray(input rayid_t id, input ray_vec_t v);
    we    = 1'b1;
    waddr = id;
    wdata = v;
    @(negedge clk);
    we    = 1'b0;
  endtask

  task automatic send_hit(input scache_to_shader_t h);
    scache_data  = h;
    scache_valid = 1'b1;
    @(posedge clk);
    while (scache_stall) begin
      @(posedge clk);
    end
    @(negedge clk);
    scache_valid = 1'b0;
  endtask

  initial begin
    int gap;
    reset        = 1'b1;
    we           = 1'b0;
    waddr        = '0;
    wdata        = '0;
    scache_data  = '0;
    scache_valid = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    if (pixel_valid || reflect_valid || scache_stall) begin
      $display("An output valid or the hit stall was high right after reset");
      abort_run();
    end
    @(negedge clk);

    for (int i = 0; i < NUM_RAYS; i++) begin
      ids[i] = rayid_t'($random(seed));
      write_ray(ids[i], rand_ray());
    end

    for (int i = 0; i < NUM_HITS; i++) begin
      gap = rand_below(4);
      repeat (gap) begin
        if (rand_below(8) == 0) begin  // Rewrite a ray between hits
          we    = 1'b1;
          waddr = ids[rand_below(NUM_RAYS)];
          wdata = rand_ray();
        end else begin
          we = 1'b0;
        end
        @(negedge clk);
      end
      we = 1'b0;
      send_hit(random_hit());
    end

    while (exp_pix.size() != 0 || exp_ref.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);  // Catch outputs that should not come

    if (exp_pix.size() == 0 && exp_ref.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Expected outputs were never produced: %0d pixels, %0d reflections",
               exp_pix.size(), exp_ref.size());
      abort_run();
    end
  end

endmodule

// File: tb_shader_assert.sv
`timescale 1ns/1ns

module tb_shader_assert (
  input logic                                clk,
  input logic                                reset,
  input shader_pkg::scache_to_shader_t       scache_data,
  input logic                                scache_valid,
  input logic                                scache_stall,
  input shader_pkg::dirpint_to_sendreflect_t reflect_data,
  input logic                                reflect_valid,
  input logic                                reflect_stall,
  input shader_pkg::pixel_t                  pixel_data,
  input logic                                pixel_valid,
  input logic                                pixel_stall,
  input shader_pkg::dirpint_to_calc_direct_t calc_direct_data,
  input logic                                calc_direct_valid,
  input logic                                calc_direct_stall
);

  import shader_pkg::*;

  hit_held : assert property (@(posedge clk) disable iff (reset)
    scache_valid && scache_stall |=> scache_valid && $stable(scache_data))
    else $error("Stalled hit input dropped valid or changed data");

  pixel_held : assert property (@(posedge clk) disable iff (reset)
    pixel_valid && pixel_stall |=> pixel_valid && $stable(pixel_data))
    else $error("Stalled pixel output dropped valid or changed data");

  // First cycle out of reset
  idle_after_reset : assert property (@(posedge clk)
    $fell(reset) |-> !pixel_valid && !reflect_valid && !scache_stall)
    else $error("Output valid or hit stall high right after reset");

  // A bounce leaves only together with its record on the shading link
  reflect_with_direct : assert property (@(posedge clk) disable iff (reset)
    reflect_valid && !reflect_stall |->
      calc_direct_valid && !calc_direct_stall &&
      calc_direct_data.rayid == reflect_data.rayid &&
      calc_direct_data.p_int == reflect_data.p_int)
    else $error("Reflection sent without the matching shading transfer");

endmodule

bind shader_top tb_shader_assert u_shader_assert (
  .clk               (clk),
  .reset             (reset),
  .scache_data       (scache_data),
  .scache_valid      (scache_valid),
  .scache_stall      (scache_stall),
  .reflect_data      (reflect_data),
  .reflect_valid     (reflect_valid),
  .reflect_stall     (reflect_stall),
  .pixel_data        (pixel_data),
  .pixel_valid       (pixel_valid),
  .pixel_stall       (pixel_stall),
  .calc_direct_data  (calc_direct_data),
  .calc_direct_valid (calc_direct_valid),
  .calc_direct_stall (calc_direct_stall)
);
